/* bench/fetch_tb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_tb;

	logic                clock;
	logic                reset;
	logic                enable_pc;
	logic                imem_we;
	logic [`IMEM_AW-1:0] imem_waddr;
	logic [31:0]         imem_wdata;
	logic                reg_we;
	logic [4:0]          reg_waddr;
	logic [31:0]         reg_wdata;
	logic                do_hazard;
	logic                do_halt_pc;
	logic                do_interrupt;
	logic [31:0]         interrupt_pc;
	logic                do_it_load_pc;
	logic [31:0]         it_return_pc;
	logic [31:0]         current_pc;
	logic [31:0]         decode_pc;
	logic                decode_valid;
	logic                do_flush_reg1;

	integer        fd;
	integer        lines;
	integer        cycle;
	integer        errors;
	integer        test_errors;
	integer        pass_count;
	integer        fail_count;
	logic          done;
	logic          aborted;
	logic          in_reset;
	reg [8*32-1:0] tok;
	reg [8*32-1:0] name;
	reg [8*200-1:0] rest;
	logic [31:0]   col [0:8];
	logic [31:0]   shadow [0:31];
	logic [31:0]   lfsr_state;
	logic [31:0]   rand_val;
	logic [31:0]   exp_pc;
	logic [31:0]   exp_decode_pc;

	fetch_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Zero-compare condition table.
	function automatic logic cond_taken(input logic [31:0] v, input logic [3:0] cond);
		case (cond)
			4'd2:    cond_taken = (v == 0);
			4'd3:    cond_taken = (v != 0);
			4'd4:    cond_taken = !v[31];
			4'd5:    cond_taken = v[31];
			4'd6:    cond_taken = (v != 0) && !v[31];
			4'd7:    cond_taken = (v == 0) || v[31];
			default: cond_taken = 1'b0;
		endcase
	endfunction

	task automatic random_word(output logic [31:0] v);
		v = 32'd0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic compare_value(input logic [31:0] expected, input logic [31:0] actual,
			input reg [8*8-1:0] what);
		if (expected !== actual) begin
			$display("** Error at %0t: %0s cycle %0d %0s expected %h got %h",
				$time, name, cycle, what, expected, actual);
			errors = errors + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic step;
		@(posedge clock);
		#10;
		cycle = cycle + 1;
	endtask

	// ----------------------------------------
	// Test setup.
	// ----------------------------------------
	task automatic start_test;
		reset = 1'b0;
		enable_pc = 1'b0;
		do_hazard = 1'b0;
		do_halt_pc = 1'b0;
		do_interrupt = 1'b0;
		do_it_load_pc = 1'b0;
		in_reset = 1'b1;
		test_errors = 0;
		for (int i = 0; i < `IMEM_WORDS; i++) begin
			imem_we = 1'b1;
			imem_waddr = i;
			imem_wdata = {24'h0, i[7:0]};
			step();
		end
		imem_we = 1'b0;
		reset = 1'b1;
		repeat (4) step();
		reset = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = 32'd0;
		end
	endtask

	task automatic release_reset;
		integer n;
		if (in_reset) begin
			reset = 1'b0;
			enable_pc = 1'b0;
			step();
			cycle = 0;
			n = 0;
			while ((current_pc !== `RESET_PC || decode_valid !== 1'b0) && n < 8) begin
				step();
				n = n + 1;
			end
			if (n >= 8) begin
				$display("Reset did not settle within 8 cycles in test %0s", name);
				errors = errors + 1;
				aborted = 1'b1;
			end
			compare_value(32'd0, {31'd0, do_flush_reg1}, "flush");
			exp_pc = `RESET_PC;
			in_reset = 1'b0;
		end
	endtask

	task automatic write_imem(input logic [31:0] addr, input logic [31:0] word);
		imem_we = 1'b1;
		imem_waddr = addr[9:2];
		imem_wdata = word;
		step();
		imem_we = 1'b0;
	endtask

	task automatic write_reg(input logic [4:0] r, input logic [31:0] v);
		release_reset();
		reg_we = 1'b1;
		reg_waddr = r;
		reg_wdata = v;
		step();
		reg_we = 1'b0;
		if (r != 0)
			shadow[r] = v;
	endtask

	// One TY_BZ placed at addr, entered through an interrupt.
	task automatic bz_case(input logic [31:0] addr, input logic [4:0] r,
			input logic [3:0] cond, input logic [15:0] imm);
		logic        taken;
		logic [31:0] target;
		integer      offset;
		release_reset();
		enable_pc = 1'b0;
		write_imem(addr, {1'b0, `TY_BZ, r, cond, imm});
		taken = cond_taken(shadow[r], cond);
		offset = $signed(imm);
		target = addr + offset * 2;
		enable_pc = 1'b1;
		do_interrupt = 1'b1;
		interrupt_pc = addr;
		step();
		compare_value(addr, current_pc, "pc");
		do_interrupt = 1'b0;
		step();
		compare_value(addr + 32'd4, current_pc, "pc");
		compare_value(addr, decode_pc, "dec_pc");
		compare_value({31'd0, taken}, {31'd0, do_flush_reg1}, "flush");
		step();
		compare_value(taken ? target : addr + 32'd8, current_pc, "pc");
		compare_value({31'd0, !taken}, {31'd0, decode_valid}, "valid");
		exp_pc = taken ? target : addr + 32'd8;
	endtask

	task automatic run_cycle;
		release_reset();
		enable_pc = col[0][0];
		do_hazard = col[1][0];
		do_halt_pc = col[2][0];
		do_interrupt = col[3][0];
		do_it_load_pc = col[4][0];
		interrupt_pc = col[5];
		it_return_pc = col[6];
		// A free-running cycle drops the slot only behind a taken redirect.
		if (col[0][0] && !col[1][0] && !col[2][0] && !col[3][0] && !col[4][0]) begin
			compare_value({31'd0, !col[8][0]}, {31'd0, do_flush_reg1}, "flush");
		end
		step();
		compare_value(col[7], current_pc, "pc");
		compare_value(col[8], {31'd0, decode_valid}, "valid");
		if (col[8][0]) begin
			if (col[0][0] && !col[1][0]) begin
				exp_decode_pc = exp_pc;
			end
			compare_value(exp_decode_pc, decode_pc, "dec_pc");
		end
		exp_pc = col[7];
	endtask

	// ----------------------------------------
	// File-driven main loop.
	// ----------------------------------------
	initial begin
		reset = 1'b1;
		enable_pc = 1'b0;
		imem_we = 1'b0;
		imem_waddr = '0;
		imem_wdata = 32'd0;
		reg_we = 1'b0;
		reg_waddr = 5'd0;
		reg_wdata = 32'd0;
		do_hazard = 1'b0;
		do_halt_pc = 1'b0;
		do_interrupt = 1'b0;
		interrupt_pc = 32'd0;
		do_it_load_pc = 1'b0;
		it_return_pc = 32'd0;
		lfsr_state = 32'hd100084d;
		exp_pc = `RESET_PC;
		exp_decode_pc = 32'd0;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		cycle = 0;
		lines = 0;
		done = 1'b0;
		aborted = 1'b0;
		in_reset = 1'b1;
		name = "none";
		fd = $fopen("bench/fetch_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/fetch_tests.txt");
			errors = errors + 1;
			done = 1'b1;
		end
		while (!done && !aborted) begin
			lines = lines + 1;
			if (lines > 2000) begin
				$display("Reading the test file did not finish within 2000 lines");
				errors = errors + 1;
				done = 1'b1;
			end else if ($fscanf(fd, "%s", tok) != 1) begin
				done = 1'b1;
			end else if (tok == "#") begin
				void'($fgets(rest, fd));
			end else if (tok == "T") begin
				void'($fscanf(fd, "%s", name));
				start_test();
			end else if (tok == "I") begin
				void'($fscanf(fd, "%h %h", col[0], col[1]));
				write_imem(col[0], col[1]);
			end else if (tok == "R") begin
				void'($fscanf(fd, "%h %h", col[0], col[1]));
				write_reg(col[0][4:0], col[1]);
			end else if (tok == "L") begin
				void'($fscanf(fd, "%h", col[0]));
				random_word(rand_val);
				write_reg(col[0][4:0], rand_val);
			end else if (tok == "C") begin
				void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
					col[3], col[4], col[5], col[6], col[7], col[8]));
				run_cycle();
			end else if (tok == "K") begin
				void'($fscanf(fd, "%h %h %h %h", col[0], col[1], col[2], col[3]));
				bz_case(col[0], col[1][4:0], col[2][3:0], col[3][15:0]);
			end else if (tok == "E") begin
				if (test_errors == 0) begin
					$display("Test %0s passed", name);
					pass_count = pass_count + 1;
				end else begin
					$display("Test %0s failed with %0d errors", name, test_errors);
					fail_count = fail_count + 1;
				end
			end else begin
				$display("Unknown directive %0s in the test file", tok);
				errors = errors + 1;
			end
		end
		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (errors == 0 && fail_count == 0 && pass_count > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* bench/fetch_tests.txt */
# T name | I byte_addr word | R reg value | L reg (LFSR value) | E ends a test
# C en hazard halt intr iret intr_pc ret_pc exp_pc exp_valid | K byte_addr reg cond imm16
T seq_fetch
C 1 0 0 0 0 0 0 4 1
C 1 0 0 0 0 0 0 8 1
C 1 0 0 0 0 0 0 c 1
C 1 0 0 0 0 0 0 10 1
E
T branch_b
I 4 4c118010
I 8 4c114010
I c 4c110012
I 30 4c11fff8
R 1 5
R 2 5
R 3 7
C 1 0 0 0 0 0 0 4 1
C 1 0 0 0 0 0 0 8 1
C 1 0 0 0 0 0 0 c 1
C 1 0 0 0 0 0 0 10 1
C 1 0 0 0 0 0 0 30 0
C 1 0 0 0 0 0 0 34 1
C 1 0 0 0 0 0 0 20 0
C 1 0 0 0 0 0 0 24 1
E
T branch_bz
R 4 0
R 5 9
R 6 80000010
L 7
L 8
K 40 4 2 20
K 80 4 3 20
K c0 4 6 20
K 100 4 7 ffe0
K 140 5 4 20
K 180 5 5 20
K 1c0 5 6 20
K 200 5 7 20
K 240 6 2 20
K 280 6 4 20
K 2c0 6 5 20
K 300 6 7 20
K 340 7 3 20
K 380 7 6 20
K 3c0 8 4 20
K 20 8 7 20
E
T jump
I 4 48ff0010
I 24 4a002400
R 9 100
C 1 0 0 0 0 0 0 4 1
C 1 0 0 0 0 0 0 8 1
C 1 0 0 0 0 0 0 fffe0024 0
C 1 0 0 0 0 0 0 fffe0028 1
C 1 0 0 0 0 0 0 100 0
C 1 0 0 0 0 0 0 104 1
E
T stall_halt
C 1 0 0 0 0 0 0 4 1
C 1 1 0 0 0 0 0 4 1
C 0 0 0 0 0 0 0 4 1
C 1 0 0 0 0 0 0 8 1
C 1 0 1 0 0 0 0 8 0
C 1 0 0 0 0 0 0 c 1
E
T interrupt
C 1 0 0 0 0 200 300 4 1
C 1 0 0 1 0 200 300 200 0
C 1 0 0 0 0 200 300 204 1
C 1 0 0 0 1 200 300 300 0
C 1 0 0 1 1 200 300 300 0
C 1 1 0 1 0 200 300 200 0
C 1 0 0 0 0 200 300 204 1
E

/* rtl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ----------------------------------------
// Major opcodes, bits 30:25.
// ----------------------------------------
`define TY_B  6'h26
`define TY_BZ 6'h27
`define TY_J  6'h24
`define TY_JR 6'h25

// Compare sub-opcode of TY_B, bit 14.
`define BEQ 1'b0
`define BNE 1'b1

// Zero-compare sub-opcodes of TY_BZ, bits 19:16.
`define BEQZ 4'd2
`define BNEZ 4'd3
`define BGEZ 4'd4
`define BLTZ 4'd5
`define BGTZ 4'd6
`define BLEZ 4'd7

// ----------------------------------------
// Reset vector and storage sizes.
// ----------------------------------------
`define RESET_PC   32'h0000_0000
`define IMEM_WORDS 256
`define IMEM_AW    8
`define NUM_REGS   32

`endif

/* rtl/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

	// ----------------------------------------
	// Encodings.
	// ----------------------------------------
	typedef enum logic [5:0] {
		OP_B     = `TY_B,
		OP_BZ    = `TY_BZ,
		OP_J     = `TY_J,
		OP_JR    = `TY_JR,
		OP_OTHER = 6'h3f
	} opcode_e;

	typedef enum logic [3:0] {
		BZ_EQZ = `BEQZ,
		BZ_NEZ = `BNEZ,
		BZ_GEZ = `BGEZ,
		BZ_LTZ = `BLTZ,
		BZ_GTZ = `BGTZ,
		BZ_LEZ = `BLEZ
	} bz_cond_e;

	// Next-PC source.
	typedef enum logic [2:0] {
		PC_4        = 3'd0,
		PC_14BIT    = 3'd1,
		PC_16BIT    = 3'd2,
		PC_24BIT    = 3'd3,
		PC_REGISTER = 3'd4
	} pc_sel_e;

	// REG1 command from the PC unit.
	typedef enum logic [1:0] {
		FC_LOAD  = 2'd0,
		FC_HOLD  = 2'd1,
		FC_FLUSH = 2'd2
	} fetch_ctl_e;

	// ----------------------------------------
	// Pipeline records.
	// ----------------------------------------
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_word_t;

	typedef struct packed {
		opcode_e     opcode;
		logic        sub_op_b;
		bz_cond_e    sub_op_bz;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [13:0] imm_14bit;
		logic [15:0] imm_16bit;
		logic [23:0] imm_24bit;
	} decode_t;

	typedef struct packed {
		logic rt_ra_equal;
		logic rt_zero;
		logic rt_negative;
	} cmp_flags_t;

endpackage

/* rtl/fetch_reg.sv */
`timescale 1ns/1ps

module fetch_reg
	import cpu_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  fetch_ctl_e  fetch_ctl,
	input  logic [31:0] pc,
	input  logic [31:0] instr,
	output fetch_word_t reg1
);

	logic        valid_q;
	logic [31:0] pc_q;
	logic [31:0] instr_q;

	// Valid bit, cleared by reset and flush.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			case (fetch_ctl)
				FC_LOAD:  valid_q <= 1'b1;
				FC_FLUSH: valid_q <= 1'b0;
				default:  valid_q <= valid_q;
			endcase
		end
	end

	// Payload only moves on a load.
	always_ff @(posedge clock) begin
		if (fetch_ctl == FC_LOAD) begin
			pc_q    <= pc;
			instr_q <= instr;
		end
	end

	always_comb begin
		reg1.valid = valid_q;
		reg1.pc    = pc_q;
		reg1.instr = instr_q;
	end

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_top
	import cpu_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                enable_pc,
	input  logic                imem_we,
	input  logic [`IMEM_AW-1:0] imem_waddr,
	input  logic [31:0]         imem_wdata,
	input  logic                reg_we,
	input  logic [4:0]          reg_waddr,
	input  logic [31:0]         reg_wdata,
	input  logic                do_hazard,
	input  logic                do_halt_pc,
	input  logic                do_interrupt,
	input  logic [31:0]         interrupt_pc,
	input  logic                do_it_load_pc,
	input  logic [31:0]         it_return_pc,
	output logic [31:0]         current_pc,
	output logic [31:0]         decode_pc,
	output logic                decode_valid,
	output logic                do_flush_reg1
);

	logic [31:0] instr;
	logic [31:0] reg_rb_data;
	fetch_ctl_e  fetch_ctl;
	fetch_word_t reg1;
	decode_t     decode;
	cmp_flags_t  flags;

	// ----------------------------------------
	// Fetch stage.
	// ----------------------------------------
	inst_mem u_inst_mem (
		.clock      (clock),
		.imem_we    (imem_we),
		.imem_waddr (imem_waddr),
		.imem_wdata (imem_wdata),
		.pc         (current_pc),
		.instr      (instr)
	);

	pc_unit u_pc_unit (
		.clock         (clock),
		.reset         (reset),
		.enable_pc     (enable_pc),
		.decode        (decode),
		.flags         (flags),
		.reg_rb_data   (reg_rb_data),
		.do_hazard     (do_hazard),
		.do_halt_pc    (do_halt_pc),
		.do_interrupt  (do_interrupt),
		.interrupt_pc  (interrupt_pc),
		.do_it_load_pc (do_it_load_pc),
		.it_return_pc  (it_return_pc),
		.current_pc    (current_pc),
		.do_flush_reg1 (do_flush_reg1),
		.fetch_ctl     (fetch_ctl)
	);

	fetch_reg u_fetch_reg (
		.clock     (clock),
		.reset     (reset),
		.fetch_ctl (fetch_ctl),
		.pc        (current_pc),
		.instr     (instr),
		.reg1      (reg1)
	);

	// ----------------------------------------
	// Decode and resolve.
	// ----------------------------------------
	inst_decode u_inst_decode (
		.reg1   (reg1),
		.decode (decode)
	);

	reg_file u_reg_file (
		.clock       (clock),
		.reset       (reset),
		.reg_we      (reg_we),
		.reg_waddr   (reg_waddr),
		.reg_wdata   (reg_wdata),
		.decode      (decode),
		.flags       (flags),
		.reg_rb_data (reg_rb_data)
	);

	assign decode_pc    = reg1.pc;
	assign decode_valid = reg1.valid;

endmodule

/* rtl/inst_decode.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module inst_decode
	import cpu_pkg::*;
(
	input  fetch_word_t reg1,
	output decode_t     decode
);

	logic [31:0] w;
	logic [5:0]  op_raw;
	logic        bz_known;

	assign w      = reg1.instr;
	assign op_raw = w[30:25];

	// ----------------------------------------
	// Field slices.
	// ----------------------------------------
	always_comb begin
		decode.sub_op_b  = w[14];
		decode.rt        = w[24:20];
		decode.ra        = w[19:15];
		decode.rb        = w[14:10];
		decode.imm_14bit = w[13:0];
		decode.imm_16bit = w[15:0];
		decode.imm_24bit = w[23:0];
	end

	// Zero-compare condition.
	always_comb begin
		bz_known         = 1'b1;
		decode.sub_op_bz = BZ_EQZ;
		case (w[19:16])
			`BEQZ:   decode.sub_op_bz = BZ_EQZ;
			`BNEZ:   decode.sub_op_bz = BZ_NEZ;
			`BGEZ:   decode.sub_op_bz = BZ_GEZ;
			`BLTZ:   decode.sub_op_bz = BZ_LTZ;
			`BGTZ:   decode.sub_op_bz = BZ_GTZ;
			`BLEZ:   decode.sub_op_bz = BZ_LEZ;
			default: bz_known = 1'b0;
		endcase
	end

	// ----------------------------------------
	// Opcode recognition.
	// ----------------------------------------
	always_comb begin
		decode.opcode = OP_OTHER;
		if (reg1.valid) begin
			case (op_raw)
				`TY_B:   decode.opcode = OP_B;
				`TY_BZ:  decode.opcode = bz_known ? OP_BZ : OP_OTHER;
				`TY_J:   decode.opcode = OP_J;
				`TY_JR:  decode.opcode = OP_JR;
				default: decode.opcode = OP_OTHER;
			endcase
		end
	end

endmodule

/* rtl/inst_mem.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module inst_mem (
	input  logic                clock,
	input  logic                imem_we,
	input  logic [`IMEM_AW-1:0] imem_waddr,
	input  logic [31:0]         imem_wdata,
	input  logic [31:0]         pc,
	output logic [31:0]         instr
);

	logic [31:0]         mem [0:`IMEM_WORDS-1];
	logic [`IMEM_AW-1:0] raddr;

	// Word index from the byte PC.
	assign raddr = pc[`IMEM_AW+1:2];

	// ----------------------------------------
	// Write port.
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (imem_we) begin
			mem[imem_waddr] <= imem_wdata;
		end
	end

	// ----------------------------------------
	// Read port.
	// ----------------------------------------
	// Asynchronous, old data during a write cycle.
	assign instr = mem[raddr];

endmodule

/* rtl/pc_unit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module pc_unit
	import cpu_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        enable_pc,
	input  decode_t     decode,
	input  cmp_flags_t  flags,
	input  logic [31:0] reg_rb_data,
	input  logic        do_hazard,
	input  logic        do_halt_pc,
	input  logic        do_interrupt,
	input  logic [31:0] interrupt_pc,
	input  logic        do_it_load_pc,
	input  logic [31:0] it_return_pc,
	output logic [31:0] current_pc,
	output logic        do_flush_reg1,
	output fetch_ctl_e  fetch_ctl
);

	pc_sel_e     select_pc;
	logic [31:0] branch_pc;
	logic [31:0] next_pc;
	logic [31:0] pc_d;
	logic        bz_taken;

	// ----------------------------------------
	// Branch condition.
	// ----------------------------------------
	always_comb begin
		case (decode.sub_op_bz)
			BZ_EQZ:  bz_taken = flags.rt_zero;
			BZ_NEZ:  bz_taken = !flags.rt_zero;
			BZ_GEZ:  bz_taken = !flags.rt_negative;
			BZ_LTZ:  bz_taken = flags.rt_negative;
			BZ_GTZ:  bz_taken = !flags.rt_zero && !flags.rt_negative;
			BZ_LEZ:  bz_taken = flags.rt_zero || flags.rt_negative;
			default: bz_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (decode.opcode)
			OP_B: begin
				if ((decode.sub_op_b == `BEQ) == flags.rt_ra_equal)
					select_pc = PC_14BIT;
				else
					select_pc = PC_4;
			end
			OP_BZ:   select_pc = bz_taken ? PC_16BIT : PC_4;
			OP_J:    select_pc = PC_24BIT;
			OP_JR:   select_pc = PC_REGISTER;
			default: select_pc = PC_4;
		endcase
	end

	// ----------------------------------------
	// Target arithmetic.
	// ----------------------------------------
	// Branch sits one word behind the fetch PC.
	assign branch_pc = current_pc - 32'd4;

	always_comb begin
		case (select_pc)
			PC_14BIT:    next_pc = branch_pc + {{17{decode.imm_14bit[13]}}, decode.imm_14bit, 1'b0};
			PC_16BIT:    next_pc = branch_pc + {{15{decode.imm_16bit[15]}}, decode.imm_16bit, 1'b0};
			PC_24BIT:    next_pc = branch_pc + {{7{decode.imm_24bit[23]}}, decode.imm_24bit, 1'b0};
			PC_REGISTER: next_pc = reg_rb_data;
			default:     next_pc = current_pc + 32'd4;
		endcase
	end

	assign do_flush_reg1 = (select_pc != PC_4);

	// ----------------------------------------
	// Redirect and stall priority.
	// ----------------------------------------
	always_comb begin
		pc_d      = current_pc;
		fetch_ctl = FC_HOLD;
		if (enable_pc) begin
			if (do_it_load_pc) begin
				pc_d      = it_return_pc;
				fetch_ctl = FC_FLUSH;
			end else if (do_interrupt) begin
				pc_d      = interrupt_pc;
				fetch_ctl = FC_FLUSH;
			end else if (do_hazard) begin
				fetch_ctl = FC_HOLD;
			end else if (do_halt_pc) begin
				fetch_ctl = FC_FLUSH;
			end else begin
				pc_d      = next_pc;
				fetch_ctl = do_flush_reg1 ? FC_FLUSH : FC_LOAD;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= `RESET_PC;
		end else begin
			current_pc <= pc_d;
		end
	end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file
	import cpu_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        reg_we,
	input  logic [4:0]  reg_waddr,
	input  logic [31:0] reg_wdata,
	input  decode_t     decode,
	output cmp_flags_t  flags,
	output logic [31:0] reg_rb_data
);

	logic [31:0] regs [0:`NUM_REGS-1];
	logic [31:0] rt_data;
	logic [31:0] ra_data;

	// ----------------------------------------
	// Write port.
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (reg_we && (reg_waddr != 5'd0)) begin
			regs[reg_waddr] <= reg_wdata;
		end
	end

	// ----------------------------------------
	// Read ports.
	// ----------------------------------------
	// r0 is hardwired to zero.
	assign rt_data     = (decode.rt == 5'd0) ? 32'd0 : regs[decode.rt];
	assign ra_data     = (decode.ra == 5'd0) ? 32'd0 : regs[decode.ra];
	assign reg_rb_data = (decode.rb == 5'd0) ? 32'd0 : regs[decode.rb];

	// Compare flags for branch resolution.
	always_comb begin
		flags.rt_ra_equal = (rt_data == ra_data);
		flags.rt_zero     = (rt_data == 32'd0);
		flags.rt_negative = rt_data[31];
	end

endmodule

/* src.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/inst_mem.sv
rtl/pc_unit.sv
rtl/fetch_reg.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/fetch_top.sv
bench/fetch_tb.sv
